// ==== vlog.f ====
+incdir+include
design/egr_types_pkg.sv
design/egr_ctrl_pkg.sv
design/egr_tag_fifo.sv
design/egr_seg_mem.sv
design/egr_word_counter.sv
design/egr_sched_fsm.sv
design/egr_port_mux.sv
design/egr_top.sv
dv/egr_clk_gen.sv
dv/egr_tb.sv

// ==== Makefile ====
# Verilator build and run for the egress slice testbench

VERILATOR ?= verilator
TOP       ?= egr_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/egr_tb.sv ====
/* Table-driven testbench for the egress slice.
   Preloads segment memory, sends tag groups and checks every port stream. */

`timescale 1ns/1ps
`default_nettype none

`include "egr_defs.svh"

module egr_tb;

  import egr_types_pkg::*;

  localparam int NUM_ENTRIES  = 15;
  localparam int WAIT_LIMIT   = 64;
  localparam int QUIET_CYCLES = 8;

  // One tag plus the enable mask in force while its group runs
  typedef struct {
    mem_addr_t  addr;
    pkt_len_t   len;
    port_id_t   port;
    port_mask_t mask;
    logic       grp_end;
    logic       fill;
  } entry_t;

  logic       egress_clock;
  logic       arst_n;
  logic       mem_wr_en;
  mem_addr_t  mem_wr_addr;
  word_t      mem_wr_data;
  logic       tag_valid;
  mem_addr_t  tag_addr;
  pkt_len_t   tag_len;
  port_id_t   tag_port;
  port_mask_t port_enable;
  port_mask_t tx_valid;
  port_mask_t tx_sop;
  port_mask_t tx_eop;
  word_t      tx_data;
  logic       tag_full;
  logic       pkt_drop;

  entry_t stim_tab [NUM_ENTRIES];
  int     seed = 32'hf577;

  egr_clk_gen #(.PERIOD_NS(4)) u_clk_gen (.clock(egress_clock));

  egr_top u_dut (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .tag_valid    (tag_valid),
    .tag_addr     (tag_addr),
    .tag_len      (tag_len),
    .tag_port     (tag_port),
    .port_enable  (port_enable),
    .tx_valid     (tx_valid),
    .tx_sop       (tx_sop),
    .tx_eop       (tx_eop),
    .tx_data      (tx_data),
    .tag_full     (tag_full),
    .pkt_drop     (pkt_drop)
  );

  // ==========================================================================
  // Failure reporting and compares
  // ==========================================================================

  task automatic stop_on_fail();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles at %0t: %s", WAIT_LIMIT, $time, what);
    stop_on_fail();
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_fail();
    end
  endtask

  task automatic check_port(input string name, input port_id_t act, input port_id_t exp);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_on_fail();
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_fail();
    end
  endtask

  // ==========================================================================
  // Reference rules
  // ==========================================================================

  // Preload pattern, word at address a
  function automatic word_t expected_word(input int a);
    return word_t'(32'hA500_0000) + word_t'(a);
  endfunction

  function automatic port_mask_t port_bit(input port_id_t p);
    return port_mask_t'(1) << p;
  endfunction

  // Lowest set bit of a port mask
  function automatic port_id_t port_of(input port_mask_t m);
    port_id_t r;
    r = '0;
    for (int p = `EGR_NUM_PORTS - 1; p >= 0; p--) begin
      if (m[p]) r = port_id_t'(p);
    end
    return r;
  endfunction

  // ==========================================================================
  // Stimulus table
  // ==========================================================================

  // Length 0 here means draw one from 1 to 16
  task automatic set_entry(input int idx, input int addr, input int len, input int port,
                           input int mask, input int grp_end, input int fill);
    int rnd;
    int l;
    l = len;
    if (len == 0) begin
      rnd = $random(seed);
      l   = 1 + int'($unsigned(rnd) % 32'd16);
    end
    stim_tab[idx].addr    = mem_addr_t'(addr);
    stim_tab[idx].len     = pkt_len_t'(l);
    stim_tab[idx].port    = port_id_t'(port);
    stim_tab[idx].mask    = port_mask_t'(mask);
    stim_tab[idx].grp_end = (grp_end != 0);
    stim_tab[idx].fill    = (fill != 0);
  endtask

  task automatic build_table();
    // Single packet, then a one-word packet
    set_entry(0, 10, 8, 0, 15, 1, 0);
    set_entry(1, 40, 1, 2, 15, 1, 0);
    // Four tags on consecutive cycles
    set_entry(2, 64, 0, 1, 15, 0, 0);
    set_entry(3, 100, 0, 3, 15, 0, 0);
    set_entry(4, 130, 0, 0, 15, 0, 0);
    set_entry(5, 160, 0, 2, 15, 1, 0);
    // Wraps past the top of memory
    set_entry(6, 250, 12, 1, 15, 1, 0);
    // Port 3 disabled, two drops then a good packet
    set_entry(7, 20, 6, 3, 7, 0, 0);
    set_entry(8, 30, 0, 3, 7, 0, 0);
    set_entry(9, 50, 5, 0, 7, 1, 0);
    // Long packet holds the FSM while four more tags fill the FIFO
    set_entry(10, 200, 16, 2, 15, 0, 1);
    set_entry(11, 0, 3, 1, 15, 0, 0);
    set_entry(12, 5, 0, 3, 15, 0, 0);
    set_entry(13, 70, 2, 0, 15, 0, 0);
    set_entry(14, 252, 7, 2, 15, 1, 0);
  endtask

  // ==========================================================================
  // Drivers
  // ==========================================================================

  task automatic preload_memory();
    for (int a = 0; a < `EGR_MEM_DEPTH; a++) begin
      @(negedge egress_clock);
      mem_wr_en   = 1'b1;
      mem_wr_addr = mem_addr_t'(a);
      mem_wr_data = expected_word(a);
    end
    @(negedge egress_clock);
    mem_wr_en = 1'b0;
  endtask

  task automatic await_first_word();
    int waited;
    waited = 0;
    while (tx_valid == '0) begin
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("long packet never reached a port");
      @(negedge egress_clock);
    end
  endtask

  // Fewer than four waiting before each push, four after a fill group
  task automatic push_tags(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      if (stim_tab[first].fill && i == first + 1) await_first_word();
      check_flag("tag_full", tag_full, 1'b0);
      tag_valid = 1'b1;
      tag_addr  = stim_tab[i].addr;
      tag_len   = stim_tab[i].len;
      tag_port  = stim_tab[i].port;
      @(negedge egress_clock);
      tag_valid = 1'b0;
    end
    if (stim_tab[first].fill) check_flag("tag_full", tag_full, 1'b1);
  endtask

  // ==========================================================================
  // Monitors
  // ==========================================================================

  task automatic receive_packet(input entry_t e);
    int        waited;
    int        a;
    port_mask_t others;
    waited = 0;
    others = ~port_bit(e.port);
    @(negedge egress_clock);
    while (tx_valid == '0) begin
      check_flag("pkt_drop", pkt_drop, 1'b0);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("expected packet never started");
      @(negedge egress_clock);
    end
    // Words must be back to back on the tagged port only
    for (int i = 0; i < int'(e.len); i++) begin
      if (i > 0) @(negedge egress_clock);
      a = (int'(e.addr) + i) % `EGR_MEM_DEPTH;
      check_flag("tx_valid one-hot", $onehot(tx_valid), 1'b1);
      check_port("tx_valid port", port_of(tx_valid), e.port);
      check_word("tx_data", tx_data, expected_word(a));
      check_flag("tx_sop", tx_sop[e.port], i == 0);
      check_flag("tx_eop", tx_eop[e.port], i == int'(e.len) - 1);
      check_flag("tx_sop other ports", |(tx_sop & others), 1'b0);
      check_flag("tx_eop other ports", |(tx_eop & others), 1'b0);
      check_flag("pkt_drop", pkt_drop, 1'b0);
    end
  endtask

  task automatic absorb_drop();
    int waited;
    waited = 0;
    @(negedge egress_clock);
    while (!pkt_drop) begin
      check_flag("tx_valid during drop", |tx_valid, 1'b0);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("no drop pulse for a disabled port");
      @(negedge egress_clock);
    end
    check_flag("tx_valid during drop", |tx_valid, 1'b0);
  endtask

  task automatic collect_group(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      if (stim_tab[i].mask[stim_tab[i].port]) receive_packet(stim_tab[i]);
      else absorb_drop();
    end
  endtask

  // Nothing extra after a group, FIFO drained
  task automatic check_quiet();
    for (int n = 0; n < QUIET_CYCLES; n++) begin
      @(negedge egress_clock);
      check_flag("tx_valid idle", |tx_valid, 1'b0);
      check_flag("pkt_drop idle", pkt_drop, 1'b0);
    end
    check_flag("tag_full idle", tag_full, 1'b0);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    int first;
    int last;
    arst_n      = 1'b0;
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    tag_valid   = 1'b0;
    tag_addr    = '0;
    tag_len     = '0;
    tag_port    = '0;
    port_enable = '0;
    build_table();

    // Reset for 16 cycles
    repeat (16) @(negedge egress_clock);
    check_flag("tx_valid in reset", |tx_valid, 1'b0);
    check_flag("tx_sop in reset", |tx_sop, 1'b0);
    check_flag("tx_eop in reset", |tx_eop, 1'b0);
    check_flag("pkt_drop in reset", pkt_drop, 1'b0);
    check_flag("tag_full in reset", tag_full, 1'b0);
    arst_n = 1'b1;

    preload_memory();

    first = 0;
    while (first < NUM_ENTRIES) begin
      last = first;
      while (!stim_tab[last].grp_end) last++;
      port_enable = stim_tab[first].mask;
      fork
        push_tags(first, last);
        collect_group(first, last);
      join
      check_quiet();
      first = last + 1;
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/egr_clk_gen.sv ====
/* Free-running clock for the egress testbench, 4 ns period by default. */

`timescale 1ns/1ps
`default_nettype none

module egr_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clock
);

  // Starts low so the first edge is a rising one
  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

endmodule

`default_nettype wire

// ==== design/egr_top.sv ====
/* Egress slice top level.
   Tag FIFO, scheduler, word counter, segment memory and port mux. */

`timescale 1ns/1ps
`default_nettype none

module egr_top (
  input  wire                         egress_clock,
  input  wire                         arst_n,
  input  wire                         mem_wr_en,
  input  wire egr_types_pkg::mem_addr_t  mem_wr_addr,
  input  wire egr_types_pkg::word_t      mem_wr_data,
  input  wire                         tag_valid,
  input  wire egr_types_pkg::mem_addr_t  tag_addr,
  input  wire egr_types_pkg::pkt_len_t   tag_len,
  input  wire egr_types_pkg::port_id_t   tag_port,
  input  wire egr_types_pkg::port_mask_t port_enable,
  output egr_types_pkg::port_mask_t   tx_valid,
  output egr_types_pkg::port_mask_t   tx_sop,
  output egr_types_pkg::port_mask_t   tx_eop,
  output egr_types_pkg::word_t        tx_data,
  output logic                        tag_full,
  output logic                        pkt_drop
);

  import egr_types_pkg::*;

  // ========================================================================
  // Internal nets
  // ========================================================================

  // Tag queue to scheduler
  logic      fifo_pop;
  logic      fifo_empty;
  mem_addr_t head_addr;
  pkt_len_t  head_len;
  port_id_t  head_port;

  // Counter and memory read
  logic      cnt_load;
  logic      cnt_step;
  logic      cnt_last;
  logic      rd_en;
  mem_addr_t rd_addr;
  word_t     rd_data;

  // Aligned flags for the mux
  logic      out_valid;
  logic      out_sop;
  logic      out_eop;
  port_id_t  out_port;

  // ========================================================================
  // Instances
  // ========================================================================

  egr_tag_fifo u_tag_fifo (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .push         (tag_valid),
    .push_addr    (tag_addr),
    .push_len     (tag_len),
    .push_port    (tag_port),
    .pop          (fifo_pop),
    .head_addr    (head_addr),
    .head_len     (head_len),
    .head_port    (head_port),
    .full         (tag_full),
    .empty        (fifo_empty)
  );

  egr_sched_fsm u_sched_fsm (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .fifo_empty   (fifo_empty),
    .head_port    (head_port),
    .fifo_pop     (fifo_pop),
    .cnt_load     (cnt_load),
    .cnt_step     (cnt_step),
    .rd_en        (rd_en),
    .cnt_last     (cnt_last),
    .out_valid    (out_valid),
    .out_sop      (out_sop),
    .out_eop      (out_eop),
    .out_port     (out_port)
  );

  egr_word_counter u_word_counter (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .load         (cnt_load),
    .start_addr   (head_addr),
    .len          (head_len),
    .step         (cnt_step),
    .addr         (rd_addr),
    .last         (cnt_last)
  );

  egr_seg_mem u_seg_mem (
    .egress_clock (egress_clock),
    .wr_en        (mem_wr_en),
    .wr_addr      (mem_wr_addr),
    .wr_data      (mem_wr_data),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  egr_port_mux u_port_mux (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .in_valid     (out_valid),
    .in_sop       (out_sop),
    .in_eop       (out_eop),
    .in_port      (out_port),
    .in_data      (rd_data),
    .port_enable  (port_enable),
    .tx_valid     (tx_valid),
    .tx_sop       (tx_sop),
    .tx_eop       (tx_eop),
    .tx_data      (tx_data),
    .pkt_drop     (pkt_drop)
  );

endmodule

`default_nettype wire

// ==== design/egr_port_mux.sv ====
/* Output stage that steers read words to one transmit port.
   Words for a disabled port are discarded with a drop pulse at eop. */

`timescale 1ns/1ps
`default_nettype none

module egr_port_mux (
  input  wire                         egress_clock,
  input  wire                         arst_n,
  input  wire                         in_valid,
  input  wire                         in_sop,
  input  wire                         in_eop,
  input  wire egr_types_pkg::port_id_t   in_port,
  input  wire egr_types_pkg::word_t      in_data,
  input  wire egr_types_pkg::port_mask_t port_enable,
  output egr_types_pkg::port_mask_t   tx_valid,
  output egr_types_pkg::port_mask_t   tx_sop,
  output egr_types_pkg::port_mask_t   tx_eop,
  output egr_types_pkg::word_t        tx_data,
  output logic                        pkt_drop
);

  import egr_types_pkg::*;

  // Enable captured at sop for the whole packet
  logic       pkt_en_q;
  logic       cur_en;
  port_mask_t port_sel;
  logic       fwd;

  always_comb begin
    port_sel          = '0;
    port_sel[in_port] = 1'b1;
  end

  // Live enable on the first word and the held value after
  assign cur_en = in_sop ? port_enable[in_port] : pkt_en_q;
  assign fwd    = in_valid && cur_en;

  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      pkt_en_q <= 1'b0;
      tx_valid <= '0;
      tx_sop   <= '0;
      tx_eop   <= '0;
      pkt_drop <= 1'b0;
    end else begin
      if (in_valid && in_sop) pkt_en_q <= port_enable[in_port];
      tx_valid <= fwd ? port_sel : '0;
      tx_sop   <= (fwd && in_sop) ? port_sel : '0;
      tx_eop   <= (fwd && in_eop) ? port_sel : '0;
      pkt_drop <= in_valid && in_eop && !cur_en;
    end
  end

  // Shared data bus qualified by tx_valid
  always_ff @(posedge egress_clock) begin
    if (in_valid) tx_data <= in_data;
  end

  // Packet flags only travel with a word
  a_flags_valid: assert property (@(posedge egress_clock) disable iff (!arst_n)
    (in_sop || in_eop) |-> in_valid);

  // Packets arrive from the scheduler without holes
  a_contiguous: assert property (@(posedge egress_clock) disable iff (!arst_n)
    (in_valid && !in_sop) |-> $past(in_valid));

endmodule

`default_nettype wire

// ==== design/egr_sched_fsm.sv ====
/* Egress scheduler FSM.
   Pops tags, drives the counter and memory reads, aligns flags with read data. */

`timescale 1ns/1ps
`default_nettype none

module egr_sched_fsm (
  input  wire                       egress_clock,
  input  wire                       arst_n,
  input  wire                       fifo_empty,
  input  wire egr_types_pkg::port_id_t head_port,
  output logic                      fifo_pop,
  output logic                      cnt_load,
  output logic                      cnt_step,
  output logic                      rd_en,
  input  wire                       cnt_last,
  output logic                      out_valid,
  output logic                      out_sop,
  output logic                      out_eop,
  output egr_types_pkg::port_id_t   out_port
);

  import egr_types_pkg::*;
  import egr_ctrl_pkg::*;

  sched_state_t state;
  sched_state_t state_nxt;

  // First read of the packet still to come
  logic     sop_pend;
  logic     rd_sop;
  port_id_t port_q;

  // ========================================================================
  // State machine
  // ========================================================================

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (!fifo_empty) state_nxt = LOAD;
      LOAD:    state_nxt = READ;
      READ:    if (cnt_last) state_nxt = GAP;
      GAP:     state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      sop_pend <= 1'b0;
      port_q   <= '0;
    end else begin
      state <= state_nxt;
      // Head registers hold the popped tag during LOAD
      if (cnt_load) begin
        sop_pend <= 1'b1;
        port_q   <= head_port;
      end else if (rd_en) begin
        sop_pend <= 1'b0;
      end
    end
  end

  assign fifo_pop = (state == IDLE) && !fifo_empty;
  assign cnt_load = (state == LOAD);
  assign rd_en    = (state == READ);
  assign cnt_step = rd_en;
  assign rd_sop   = rd_en && sop_pend;

  // ========================================================================
  // Alignment with memory read data
  // ========================================================================

  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_sop   <= 1'b0;
      out_eop   <= 1'b0;
      out_port  <= '0;
    end else begin
      out_valid <= rd_en;
      out_sop   <= rd_sop;
      out_eop   <= rd_en && cnt_last;
      out_port  <= port_q;
    end
  end

  // Outside READ the counter holds no words
  a_cnt_drained: assert property (@(posedge egress_clock) disable iff (!arst_n)
    (state != READ) |-> !cnt_last);

endmodule

`default_nettype wire

// ==== design/egr_word_counter.sv ====
/* Read address generator for one packet.
   Loaded with the tag, stepped once per read word. */

`timescale 1ns/1ps
`default_nettype none

`include "egr_defs.svh"

module egr_word_counter (
  input  wire                        egress_clock,
  input  wire                        arst_n,
  input  wire                        load,
  input  wire egr_types_pkg::mem_addr_t start_addr,
  input  wire egr_types_pkg::pkt_len_t  len,
  input  wire                        step,
  output egr_types_pkg::mem_addr_t   addr,
  output logic                       last
);

  import egr_types_pkg::*;

  // Highest word address before wrap
  localparam mem_addr_t TOP_ADDR = mem_addr_t'(`EGR_MEM_DEPTH - 1);

  // Words still to read
  pkt_len_t count;

  // Wrapping increment
  mem_addr_t addr_nxt;
  assign addr_nxt = (addr == TOP_ADDR) ? '0 : addr + mem_addr_t'(1);

  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      addr  <= '0;
      count <= '0;
    end else if (load) begin
      addr  <= start_addr;
      count <= len;
    end else if (step) begin
      addr  <= addr_nxt;
      count <= count - pkt_len_t'(1);
    end
  end

  // One word left
  assign last = (count == pkt_len_t'(1));

  // FSM must stop stepping once the packet is read
  a_no_step_zero: assert property (@(posedge egress_clock) disable iff (!arst_n)
    step |-> (count != '0));

endmodule

`default_nettype wire

// ==== design/egr_seg_mem.sv ====
/* Shared segment memory model.
   Ingress writes one word per cycle and egress reads with one cycle latency. */

`timescale 1ns/1ps
`default_nettype none

`include "egr_defs.svh"

module egr_seg_mem (
  input  wire                        egress_clock,
  input  wire                        wr_en,
  input  wire egr_types_pkg::mem_addr_t wr_addr,
  input  wire egr_types_pkg::word_t     wr_data,
  input  wire                        rd_en,
  input  wire egr_types_pkg::mem_addr_t rd_addr,
  output egr_types_pkg::word_t       rd_data
);

  import egr_types_pkg::*;

  // ========================================================================
  // Storage
  // ========================================================================

  word_t mem_q [`EGR_MEM_DEPTH];

  // Ingress write port
  always_ff @(posedge egress_clock) begin
    if (wr_en) begin
      mem_q[wr_addr] <= wr_data;
    end
  end

  // ========================================================================
  // Read port
  // ========================================================================

  // Registered read
  // Same address write in the same cycle returns the old word
  always_ff @(posedge egress_clock) begin
    if (rd_en) begin
      rd_data <= mem_q[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== design/egr_tag_fifo.sv ====
/* Tag queue between the tag strobe and the scheduler.
   A pop loads the head registers with the oldest tag. */

`timescale 1ns/1ps
`default_nettype none

`include "egr_defs.svh"

module egr_tag_fifo (
  input  wire                       egress_clock,
  input  wire                       arst_n,
  input  wire                       push,
  input  wire egr_types_pkg::mem_addr_t push_addr,
  input  wire egr_types_pkg::pkt_len_t  push_len,
  input  wire egr_types_pkg::port_id_t  push_port,
  input  wire                       pop,
  output egr_types_pkg::mem_addr_t  head_addr,
  output egr_types_pkg::pkt_len_t   head_len,
  output egr_types_pkg::port_id_t   head_port,
  output logic                      full,
  output logic                      empty
);

  import egr_types_pkg::*;

  localparam int AW = $clog2(`EGR_FIFO_DEPTH);

  // Tag storage, one array per field
  mem_addr_t addr_q [`EGR_FIFO_DEPTH];
  pkt_len_t  len_q  [`EGR_FIFO_DEPTH];
  port_id_t  port_q [`EGR_FIFO_DEPTH];

  // Extra top bit tells a full ring from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Pointers
  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Entry writes and head capture
  always_ff @(posedge egress_clock) begin
    if (push && !full) begin
      addr_q[wr_ptr[AW-1:0]] <= push_addr;
      len_q[wr_ptr[AW-1:0]]  <= push_len;
      port_q[wr_ptr[AW-1:0]] <= push_port;
    end
    if (pop && !empty) begin
      head_addr <= addr_q[rd_ptr[AW-1:0]];
      head_len  <= len_q[rd_ptr[AW-1:0]];
      head_port <= port_q[rd_ptr[AW-1:0]];
    end
  end

  // A tag strobed while full would be lost
  a_no_push_full: assert property (@(posedge egress_clock) disable iff (!arst_n)
    push |-> !full);

  // Scheduler must only pop a waiting tag
  a_no_pop_empty: assert property (@(posedge egress_clock) disable iff (!arst_n)
    pop |-> !empty);

endmodule

`default_nettype wire

// ==== design/egr_ctrl_pkg.sv ====
/* Control types for the egress scheduler. */

`default_nettype none

package egr_ctrl_pkg;

  // Scheduler sequence per tag
  // IDLE waits for a tag, LOAD primes the counter,
  // READ streams words, GAP spaces packets apart
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    READ,
    GAP
  } sched_state_t;

endpackage

`default_nettype wire

// ==== design/egr_types_pkg.sv ====
/* Data-path vector types for the egress slice.
   Shared by the RTL and the testbench. */

`default_nettype none

`include "egr_defs.svh"

package egr_types_pkg;

  // ========================================================================
  // Data path
  // ========================================================================

  // One segment memory word
  typedef logic [`EGR_WORD_W-1:0] word_t;

  // Word address into segment memory
  typedef logic [$clog2(`EGR_MEM_DEPTH)-1:0] mem_addr_t;

  // Packet length in words
  // Legal range 1 to 16, so 5 bits
  typedef logic [4:0] pkt_len_t;

  // ========================================================================
  // Port selection
  // ========================================================================

  // Destination port number
  typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] port_id_t;

  // One bit per transmit port
  typedef logic [`EGR_NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// ==== include/egr_defs.svh ====
/* Size constants for the egress slice.
   Included by the packages and RTL files that need them. */

`ifndef EGR_DEFS_SVH
`define EGR_DEFS_SVH

// ==========================================================================
// Memory and queue sizes
// ==========================================================================

// Words in the shared segment memory
`define EGR_MEM_DEPTH 256

// Tags held by the tag FIFO
// Must stay a power of two for the pointer scheme
`define EGR_FIFO_DEPTH 4

// ==========================================================================
// Port and data sizes
// ==========================================================================

// Ethernet transmit ports on the slice
`define EGR_NUM_PORTS 4

// Width of one data word
`define EGR_WORD_W 32

`endif
